// ==== fifo_testdata.txt ====
# name write read data_in(hex) exp_valid exp_data_out(hex) exp_full exp_empty exp_count
# expected outputs are sampled one falling edge after the step is driven
reset_state 0 0 00000000 0 00000000 0 1 0
reset_state 0 0 00000000 0 00000000 0 1 0
order 1 0 0000a001 0 00000000 0 0 1
order 1 0 0000a002 0 00000000 0 0 2
order 1 0 0000a003 0 00000000 0 0 3
order 0 0 00000000 0 00000000 0 0 3
order 0 1 00000000 1 0000a001 0 0 2
order 0 1 00000000 1 0000a002 0 0 1
order 0 0 00000000 0 0000a002 0 0 1
order 0 1 00000000 1 0000a003 0 1 0
empty 0 1 00000000 0 0000a003 0 1 0
empty 0 1 00000000 0 0000a003 0 1 0
full 1 0 0000b001 0 0000a003 0 0 1
full 1 0 0000b002 0 0000a003 0 0 2
full 1 0 0000b003 0 0000a003 0 0 3
full 1 0 0000b004 0 0000a003 0 0 4
full 1 0 0000b005 0 0000a003 0 0 5
full 1 0 0000b006 0 0000a003 0 0 6
full 1 0 0000b007 0 0000a003 0 0 7
full 1 0 0000b008 0 0000a003 1 0 8
full 1 0 0000b0ff 0 0000a003 1 0 8
full 0 1 00000000 1 0000b001 0 0 7
full 0 1 00000000 1 0000b002 0 0 6
full 0 1 00000000 1 0000b003 0 0 5
full 0 1 00000000 1 0000b004 0 0 4
full 0 1 00000000 1 0000b005 0 0 3
full 0 1 00000000 1 0000b006 0 0 2
full 0 1 00000000 1 0000b007 0 0 1
full 0 1 00000000 1 0000b008 0 1 0
full 0 1 00000000 0 0000b008 0 1 0
simul_mid 1 0 0000c001 0 0000b008 0 0 1
simul_mid 1 0 0000c002 0 0000b008 0 0 2
simul_mid 1 0 0000c003 0 0000b008 0 0 3
simul_mid 1 1 0000c004 1 0000c001 0 0 3
simul_mid 1 1 0000c005 1 0000c002 0 0 3
simul_full 1 0 0000c006 0 0000c002 0 0 4
simul_full 1 0 0000c007 0 0000c002 0 0 5
simul_full 1 0 0000c008 0 0000c002 0 0 6
simul_full 1 0 0000c009 0 0000c002 0 0 7
simul_full 1 0 0000c00a 0 0000c002 1 0 8
simul_full 1 1 0000c0ff 1 0000c003 0 0 7
simul_full 0 1 00000000 1 0000c004 0 0 6
simul_full 0 1 00000000 1 0000c005 0 0 5
simul_full 0 1 00000000 1 0000c006 0 0 4
simul_full 0 1 00000000 1 0000c007 0 0 3
simul_full 0 1 00000000 1 0000c008 0 0 2
simul_full 0 1 00000000 1 0000c009 0 0 1
simul_full 0 1 00000000 1 0000c00a 0 1 0
simul_empty 1 1 0000d001 0 0000c00a 0 0 1
simul_empty 0 1 00000000 1 0000d001 0 1 0
wrap 1 0 0000e000 0 0000d001 0 0 1
wrap 1 1 0000e001 1 0000e000 0 0 1
wrap 1 1 0000e002 1 0000e001 0 0 1
wrap 1 1 0000e003 1 0000e002 0 0 1
wrap 1 1 0000e004 1 0000e003 0 0 1
wrap 1 1 0000e005 1 0000e004 0 0 1
wrap 1 1 0000e006 1 0000e005 0 0 1
wrap 1 1 0000e007 1 0000e006 0 0 1
wrap 1 1 0000e008 1 0000e007 0 0 1
wrap 1 1 0000e009 1 0000e008 0 0 1
wrap 1 1 0000e00a 1 0000e009 0 0 1
wrap 0 1 00000000 1 0000e00a 0 1 0
wrap 0 0 00000000 0 0000e00a 0 1 0

// ==== sources.f ====
fifo_pkg.sv
fifo_mem_if.sv
fifo_ctrl.sv
fifo_ram.sv
fifo_top.sv
tb_fifo_top.sv

// ==== tb_fifo_top.sv ====
/*
 * Testbench for the synchronous FIFO
 * Replays per-cycle stimulus from the test data file on the falling
 * edge and checks the DUT outputs one cycle later
 */
`timescale 1ns/1ps

module tb_fifo_top;

    import fifo_pkg::*;

    localparam int DATA_WIDTH    = DATA_WIDTH_DEF;
    localparam int ADDR_WIDTH    = ADDR_WIDTH_DEF;
    localparam int MAX_STEPS     = 256;
    localparam int RESET_CYCLES  = 16;
    localparam int RESET_TIMEOUT = 64;
    localparam int RUN_TIMEOUT   = 1000;

    logic                  clk;
    logic                  reset;
    logic                  write;
    logic                  read;
    logic [DATA_WIDTH-1:0] data_in;
    logic [DATA_WIDTH-1:0] data_out;
    logic                  valid_out;
    logic                  full;
    logic                  empty;
    logic [ADDR_WIDTH:0]   count;

    // One entry per cycle, loaded from the data file
    logic [8*24-1:0]       step_name      [MAX_STEPS];
    logic                  step_write     [MAX_STEPS];
    logic                  step_read      [MAX_STEPS];
    logic [DATA_WIDTH-1:0] step_data_in   [MAX_STEPS];
    logic                  exp_valid      [MAX_STEPS];
    logic [DATA_WIDTH-1:0] exp_data_out   [MAX_STEPS];
    logic                  exp_full       [MAX_STEPS];
    logic                  exp_empty      [MAX_STEPS];
    logic [ADDR_WIDTH:0]   exp_count      [MAX_STEPS];
    int                    num_steps;
    int                    test_errors;

    fifo_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .write     (write),
        .read      (read),
        .data_in   (data_in),
        .data_out  (data_out),
        .valid_out (valid_out),
        .full      (full),
        .empty     (empty),
        .count     (count)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Clock and reset
    ////////////////////////////////////////////////////////////////////////////

    // 20 ns period
    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Released on a falling edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset <= 1'b0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test data loading
    ////////////////////////////////////////////////////////////////////////////

    // Comment and blank lines do not yield nine fields and are skipped
    task automatic load_testdata();
        int                    fd;
        int                    n;
        int                    w, r, v, f, e, c;
        logic [8*160-1:0]      line_buf;
        logic [8*24-1:0]       name_tok;
        logic [DATA_WIDTH-1:0] din;
        logic [DATA_WIDTH-1:0] dout;
        num_steps = 0;
        fd = $fopen("fifo_testdata.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line_buf = '0;
                n = $fgets(line_buf, fd);
                if (n > 0) begin
                    n = $sscanf(line_buf, "%s %d %d %h %d %h %d %d %d",
                                name_tok, w, r, din, v, dout, f, e, c);
                    if (n == 9 && num_steps < MAX_STEPS) begin
                        step_name[num_steps]    = name_tok;
                        step_write[num_steps]   = w[0];
                        step_read[num_steps]    = r[0];
                        step_data_in[num_steps] = din;
                        exp_valid[num_steps]    = v[0];
                        exp_data_out[num_steps] = dout;
                        exp_full[num_steps]     = f[0];
                        exp_empty[num_steps]    = e[0];
                        exp_count[num_steps]    = c[ADDR_WIDTH:0];
                        num_steps++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input logic [8*24-1:0] test_name, input int step,
                               input fifo_op_e op, input logic [8*12-1:0] field,
                               input logic [DATA_WIDTH-1:0] expected,
                               input logic [DATA_WIDTH-1:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch in test %0s, step %0d (%s): %0s expected %0h, actual %0h",
                     test_name, step, op.name(), field, expected, actual);
            test_errors++;
        end
    endtask

    // Outputs after the edge that sampled this step's strobes
    task automatic check_step(input int idx);
        fifo_op_e op;
        op = fifo_op_e'({step_read[idx], step_write[idx]});
        check_value(step_name[idx], idx, op, "valid_out", exp_valid[idx], valid_out);
        check_value(step_name[idx], idx, op, "data_out", exp_data_out[idx], data_out);
        check_value(step_name[idx], idx, op, "full", exp_full[idx], full);
        check_value(step_name[idx], idx, op, "empty", exp_empty[idx], empty);
        check_value(step_name[idx], idx, op, "count", exp_count[idx], count);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Replay
    ////////////////////////////////////////////////////////////////////////////

    initial begin : replay
        int  idx;
        int  wait_cycles;
        int  tests_passed;
        int  tests_failed;
        bit  aborted;
        write        = 1'b0;
        read         = 1'b0;
        data_in      = '0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        load_testdata();
        if (num_steps == 0) begin
            $display("Error: no test steps could be read from fifo_testdata.txt");
            aborted = 1'b1;
        end
        // Reset release, bounded
        wait_cycles = 0;
        while (!aborted && reset !== 1'b0) begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > RESET_TIMEOUT) begin
                $display("Timeout: reset was never released");
                aborted = 1'b1;
            end
        end
        // One step per cycle until the end of the file
        idx = 0;
        wait_cycles = 0;
        while (!aborted && idx < num_steps) begin
            write   = step_write[idx];
            read    = step_read[idx];
            data_in = step_data_in[idx];
            @(negedge clk);
            check_step(idx);
            // Test ends where the name changes
            if (idx == num_steps - 1 || step_name[idx + 1] != step_name[idx]) begin
                if (test_errors == 0) begin
                    $display("Test %0s: PASS", step_name[idx]);
                    tests_passed++;
                end else begin
                    $display("Test %0s: FAIL (%0d mismatches)", step_name[idx], test_errors);
                    tests_failed++;
                end
                test_errors = 0;
            end
            idx++;
            wait_cycles++;
            if (wait_cycles > RUN_TIMEOUT) begin
                $display("Timeout: test data replay did not reach the end of the file");
                aborted = 1'b1;
            end
        end
        write = 1'b0;
        read  = 1'b0;
        $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (!aborted && tests_failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== fifo_top.sv ====
/*
 * Synchronous FIFO top level
 * Joins the pointer/status controller and the storage array through
 * the storage access interface, with plain ports outward
 */
`timescale 1ns/1ps

module fifo_top #(
    parameter int DATA_WIDTH = fifo_pkg::DATA_WIDTH_DEF,
    parameter int ADDR_WIDTH = fifo_pkg::ADDR_WIDTH_DEF
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  write,
    input  logic                  read,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  valid_out,
    output logic                  full,
    output logic                  empty,
    output logic [ADDR_WIDTH:0]   count
);

    ////////////////////////////////////////////////////////////////////////////
    // Controller to storage link
    ////////////////////////////////////////////////////////////////////////////

    fifo_mem_if #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) mem_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // Pointer and status controller
    ////////////////////////////////////////////////////////////////////////////

    // Only place where full and empty are tested
    fifo_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ctrl (
        .clk   (clk),
        .reset (reset),
        .write (write),
        .read  (read),
        .full  (full),
        .empty (empty),
        .count (count),
        .mem   (mem_bus.ctrl)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    // Data path bypasses the controller
    fifo_ram #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ram (
        .clk       (clk),
        .reset     (reset),
        .mem       (mem_bus.mem),
        .data_in   (data_in),
        .data_out  (data_out),
        .valid_out (valid_out)
    );

endmodule

// ==== fifo_ram.sv ====
/*
 * FIFO storage array
 * RAM-style array with registered read data and a one-cycle
 * read-valid pulse; enables arrive already qualified
 */
`timescale 1ns/1ps

module fifo_ram #(
    parameter int DATA_WIDTH = fifo_pkg::DATA_WIDTH_DEF,
    parameter int ADDR_WIDTH = fifo_pkg::ADDR_WIDTH_DEF
) (
    input  logic                  clk,
    input  logic                  reset,
    fifo_mem_if.mem               mem,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  valid_out
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    // Word storage, no reset so it can map to block RAM
    logic [DATA_WIDTH-1:0] ram_array [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            ram_array[mem.wr_addr] <= data_in;
        end
    end

    // Read port, data held when no read is accepted
    always_ff @(posedge clk) begin
        if (reset) begin
            data_out  <= '0;
            valid_out <= 1'b0;
        end else if (mem.rd_en) begin
            data_out  <= ram_array[mem.rd_addr];
            valid_out <= 1'b1;
        end else begin
            // Pulse lasts one cycle only
            valid_out <= 1'b0;
        end
    end

endmodule

// ==== fifo_ctrl.sv ====
/*
 * FIFO pointer and status controller
 * Qualifies the write/read strobes against the registered flags,
 * advances the pointers and keeps occupancy, full and empty
 */
`timescale 1ns/1ps

module fifo_ctrl #(
    parameter int ADDR_WIDTH = fifo_pkg::ADDR_WIDTH_DEF
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                write,
    input  logic                read,
    output logic                full,
    output logic                empty,
    output logic [ADDR_WIDTH:0] count,
    fifo_mem_if.ctrl            mem
);

    import fifo_pkg::*;

    // Depth as a count value, one bit wider than an address
    localparam logic [ADDR_WIDTH:0] DEPTH = {1'b1, {ADDR_WIDTH{1'b0}}};

    ////////////////////////////////////////////////////////////////////////////
    // Strobe qualification and decode
    ////////////////////////////////////////////////////////////////////////////

    logic                  push_ok;
    logic                  pop_ok;
    fifo_op_e              op;
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    logic [ADDR_WIDTH:0]   count_next;

    // Flags are registered, so these are stable for the whole cycle
    assign push_ok = write && !full;
    assign pop_ok  = read && !empty;

    // Both strobes while full or empty fall out of the gating above
    always_comb begin
        case ({pop_ok, push_ok})
            2'b01:   op = OP_PUSH;
            2'b10:   op = OP_POP;
            2'b11:   op = OP_PUSH_POP;
            default: op = OP_IDLE;
        endcase
    end

    // Occupancy after this edge
    always_comb begin
        case (op)
            OP_PUSH: count_next = count + 1'b1;
            OP_POP:  count_next = count - 1'b1;
            // Idle, or push and pop cancel out
            default: count_next = count;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers
    ////////////////////////////////////////////////////////////////////////////

    // Natural wrap at the top of the address range
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (op == OP_PUSH || op == OP_PUSH_POP) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (op == OP_POP || op == OP_PUSH_POP) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Occupancy and flags
    ////////////////////////////////////////////////////////////////////////////

    // Flags come from the next count, valid from the access edge
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            full  <= 1'b0;
            empty <= 1'b1;
        end else begin
            count <= count_next;
            full  <= (count_next == DEPTH);
            empty <= (count_next == '0);
        end
    end

    // Storage side, current pointers and accepted enables
    assign mem.wr_en   = push_ok;
    assign mem.wr_addr = wr_ptr;
    assign mem.rd_en   = pop_ok;
    assign mem.rd_addr = rd_ptr;

endmodule

// ==== fifo_mem_if.sv ====
/*
 * FIFO storage access interface
 * Carries the qualified write and read enables and the pointer
 * addresses from the controller into the storage array
 */
`timescale 1ns/1ps

interface fifo_mem_if #(
    parameter int ADDR_WIDTH = fifo_pkg::ADDR_WIDTH_DEF
);

    // Write side, already gated with full
    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;

    // Read side, already gated with empty
    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] rd_addr;

    // Controller owns every signal
    modport ctrl (
        output wr_en,
        output wr_addr,
        output rd_en,
        output rd_addr
    );

    // Storage only obeys what it is given
    modport mem (
        input wr_en,
        input wr_addr,
        input rd_en,
        input rd_addr
    );

endinterface

// ==== fifo_pkg.sv ====
/*
 * FIFO shared definitions
 * Default word and address widths, and the access opcode that the
 * controller decodes from the write and read strobes each cycle
 */
package fifo_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Default widths
    ////////////////////////////////////////////////////////////////////////////

    // Word width of the storage array
    parameter int DATA_WIDTH_DEF = 32;

    // Address width, depth is 2**ADDR_WIDTH_DEF = 8 words
    parameter int ADDR_WIDTH_DEF = 3;

    ////////////////////////////////////////////////////////////////////////////
    // Access opcode
    ////////////////////////////////////////////////////////////////////////////

    // Accepted access for one cycle, after full/empty qualification
    typedef enum logic [1:0] {
        OP_IDLE     = 2'b00,
        OP_PUSH     = 2'b01,
        OP_POP      = 2'b10,
        OP_PUSH_POP = 2'b11
    } fifo_op_e;

endpackage
